//--- flist.f
source/jacobi_pkg.sv
source/jacobi_sweep_sequencer.sv
source/jacobi_matrix_ram.sv
source/jacobi_angle_operands.sv
source/jacobi_angle_front.sv
sim/jacobi_angle_front_chk.sv
sim/jacobi_angle_front_tb.sv

//--- run.sh
#!/bin/sh
# Compile and run the testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
  -f flist.f --top-module jacobi_angle_front_tb -o jacobi_angle_front_sim
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

out=$(./obj_dir/jacobi_angle_front_sim)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if echo "$out" | grep -qx "PASS: all tests"; then
  exit 0
fi
exit 1

//--- sim/jacobi_angle_front_tb.sv
`timescale 1ns/100ps

module jacobi_angle_front_tb
  import jacobi_pkg::*;
();

  localparam int N      = JACOBI_N;
  localparam int WORD_W = JACOBI_WORD_W;
  localparam int PAIRS  = N / 2;
  localparam int TOTAL  = N * (N - 1) / 2;
  // Five sweeps of about 140 cycles each, load gaps included, with margin
  localparam int TIMEOUT_CYCLES = 3000;
  localparam int SWEEP_LIMIT    = 400;

  logic                     clk;
  logic                     rst;
  logic signed [WORD_W-1:0] in_dat_i;
  logic                     in_vld_i;
  logic                     in_rdy_o;
  logic signed [WORD_W-1:0] vec_x_o;
  logic signed [WORD_W-1:0] vec_y_o;
  logic [$clog2(N)-1:0]     vec_i_o;
  logic [$clog2(N)-1:0]     vec_j_o;
  logic                     vec_vld_o;
  logic                     sweep_done_o;

  logic signed [WORD_W-1:0] mat [N][N];
  int          slot_a [PAIRS];
  int          slot_b [PAIRS];
  int          exp_i [$];
  int          exp_j [$];
  int          got_i [$];
  int          got_j [$];
  int unsigned lcg_state;
  int          errors;
  int          cycle_cnt;

  jacobi_angle_front #(
    .N      (N),
    .WORD_W (WORD_W)
  ) u_dut (
    .clk          (clk),
    .rst          (rst),
    .in_dat_i     (in_dat_i),
    .in_vld_i     (in_vld_i),
    .in_rdy_o     (in_rdy_o),
    .vec_x_o      (vec_x_o),
    .vec_y_o      (vec_y_o),
    .vec_i_o      (vec_i_o),
    .vec_j_o      (vec_j_o),
    .vec_vld_o    (vec_vld_o),
    .sweep_done_o (sweep_done_o)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  always @(posedge clk) begin
    cycle_cnt = cycle_cnt + 1;
    if (cycle_cnt >= TIMEOUT_CYCLES) begin
      $display("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
      $display("FAIL: see errors above");
      $finish;
    end
  end

  function automatic int unsigned lcg_next();
    lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
    return lcg_state >> 16;
  endfunction

  // Round-robin rotation around the fixed first element of slot 0
  function automatic void permute_slots();
    int a [PAIRS];
    int b [PAIRS];
    a = slot_a;
    b = slot_b;
    slot_b[0] = a[1];
    for (int k = 1; k < PAIRS - 1; k++) begin
      slot_a[k] = a[k+1];
    end
    slot_a[PAIRS-1] = b[PAIRS-1];
    for (int k = 1; k < PAIRS; k++) begin
      slot_b[k] = b[k-1];
    end
  endfunction

  // Expected pair order of one sweep; slot state carries over to the next
  function automatic void plan_sweep();
    exp_i.delete();
    exp_j.delete();
    for (int r = 0; r < N - 1; r++) begin
      for (int p = 0; p < PAIRS; p++) begin
        exp_i.push_back((slot_a[p] < slot_b[p]) ? slot_a[p] : slot_b[p]);
        exp_j.push_back((slot_a[p] < slot_b[p]) ? slot_b[p] : slot_a[p]);
      end
      permute_slots();
    end
  endfunction

  function automatic void fill_ramp();
    for (int r = 0; r < N; r++) begin
      for (int c = r; c < N; c++) begin
        mat[r][c] = WORD_W'(16 * r + c);
        mat[c][r] = mat[r][c];
      end
    end
  endfunction

  function automatic void fill_random();
    for (int r = 0; r < N; r++) begin
      for (int c = r; c < N; c++) begin
        mat[r][c] = WORD_W'(int'(lcg_next() % 2048) - 1024);
        mat[c][r] = mat[r][c];
      end
    end
  endfunction

  // Diagonal near full scale with alternating sign, large off-diagonal words
  function automatic void fill_wrap();
    for (int r = 0; r < N; r++) begin
      mat[r][r] = WORD_W'(30000 + int'(lcg_next() % 2000));
      if (r % 2 == 1) begin
        mat[r][r] = -mat[r][r];
      end
      for (int c = r + 1; c < N; c++) begin
        mat[r][c] = WORD_W'(16384 + int'(lcg_next() % 16000));
        if ((r + c) % 2 == 1) begin
          mat[r][c] = -mat[r][c];
        end
        mat[c][r] = mat[r][c];
      end
    end
  endfunction

  task automatic load_matrix(input string name, input bit gaps);
    int k;
    k = 0;
    while (k < N * N) begin
      if (gaps && (lcg_next() % 3 == 0)) begin
        in_vld_i <= 1'b0;
      end else begin
        in_vld_i <= 1'b1;
        in_dat_i <= mat[k / N][k % N];
      end
      @(posedge clk);
      if (vec_vld_o || sweep_done_o) begin
        $display("Test %s saw a strobe before the matrix was complete", name);
        errors++;
      end
      if (in_vld_i && in_rdy_o) begin
        k++;
      end
    end
    in_vld_i <= 1'b0;
  endtask

  // Collects one sweep and compares it with the model; junk beats are offered first
  task automatic run_sweep(input string name, input int junk_cycles);
    int                       waited;
    int                       n;
    bit                       done_seen;
    logic signed [WORD_W-1:0] ex;
    logic signed [WORD_W-1:0] ey;
    waited    = 0;
    n         = 0;
    done_seen = 1'b0;
    plan_sweep();
    got_i.delete();
    got_j.delete();
    while (!done_seen && waited < SWEEP_LIMIT) begin
      if (waited < junk_cycles) begin
        in_vld_i <= 1'b1;
        in_dat_i <= WORD_W'(lcg_next());
      end else begin
        in_vld_i <= 1'b0;
      end
      @(posedge clk);
      waited++;
      if (in_vld_i && in_rdy_o) begin
        $display("Test %s: a beat was accepted while the sweep ran", name);
        errors++;
      end
      if (vec_vld_o) begin
        if (n < TOTAL) begin
          ex = WORD_W'(int'(mat[exp_j[n]][exp_j[n]]) - int'(mat[exp_i[n]][exp_i[n]]));
          ey = WORD_W'(2 * int'(mat[exp_i[n]][exp_j[n]]));
          if (int'(vec_i_o) != exp_i[n] || int'(vec_j_o) != exp_j[n]) begin
            $display("** Error [%s] pair %0d: expected (%0d,%0d), actual (%0d,%0d)",
                     name, n, exp_i[n], exp_j[n], vec_i_o, vec_j_o);
            errors++;
          end
          if (vec_x_o != ex || vec_y_o != ey) begin
            $display("** Error [%s] pair %0d x,y: expected %0d,%0d, actual %0d,%0d",
                     name, n, ex, ey, vec_x_o, vec_y_o);
            errors++;
          end
        end else begin
          $display("Test %s: extra strobe beyond %0d pairs", name, TOTAL);
          errors++;
        end
        got_i.push_back(int'(vec_i_o));
        got_j.push_back(int'(vec_j_o));
        n++;
      end
      if (sweep_done_o) begin
        done_seen = 1'b1;
        if (!vec_vld_o) begin
          $display("Test %s: sweep_done_o came without a strobe", name);
          errors++;
        end
        if (n != TOTAL) begin
          $display("** Error [%s] strobe count: expected %0d, actual %0d", name, TOTAL, n);
          errors++;
        end
      end
    end
    in_vld_i <= 1'b0;
    if (!done_seen) begin
      $display("Test %s: sweep_done_o missing after %0d cycles", name, SWEEP_LIMIT);
      errors++;
    end
    repeat (8) begin
      @(posedge clk);
      if (vec_vld_o || sweep_done_o) begin
        $display("Test %s: strobe after the end of the sweep", name);
        errors++;
      end
    end
  endtask

  task automatic test_reset_idle();
    repeat (4) begin
      @(posedge clk);
      if (!in_rdy_o || vec_vld_o || sweep_done_o) begin
        $display("Test reset_idle: after reset in_rdy_o is low or a strobe is high");
        errors++;
      end
    end
  endtask

  task automatic test_first_round();
    fill_ramp();
    load_matrix("first_round", 1'b0);
    run_sweep("first_round", 0);
    if (got_i.size() < PAIRS) begin
      $display("Test first_round: fewer strobes than one round");
      errors++;
    end else begin
      for (int p = 0; p < PAIRS; p++) begin
        if (got_i[p] != p || got_j[p] != N - 1 - p) begin
          $display("** Error [first_round] slot %0d: expected (%0d,%0d), actual (%0d,%0d)",
                   p, p, N - 1 - p, got_i[p], got_j[p]);
          errors++;
        end
      end
    end
  endtask

  task automatic test_full_sweep();
    int seen [N][N];
    fill_ramp();
    load_matrix("full_sweep", 1'b0);
    run_sweep("full_sweep", 0);
    foreach (got_i[k]) begin
      if (got_i[k] < got_j[k]) begin
        seen[got_i[k]][got_j[k]]++;
      end
    end
    for (int i = 0; i < N; i++) begin
      for (int j = i + 1; j < N; j++) begin
        if (seen[i][j] != 1) begin
          $display("** Error [full_sweep] count of (%0d,%0d): expected 1, actual %0d",
                   i, j, seen[i][j]);
          errors++;
        end
      end
    end
  endtask

  task automatic test_gaps_busy();
    fill_random();
    load_matrix("gaps_busy", 1'b1);
    run_sweep("gaps_busy", 20);
  endtask

  task automatic test_wrap();
    fill_wrap();
    load_matrix("wrap", 1'b0);
    run_sweep("wrap", 0);
  endtask

  // Model slots are not reset, so the schedule carries on from the last sweep
  task automatic test_reload();
    fill_random();
    load_matrix("reload", 1'b0);
    run_sweep("reload", 0);
  endtask

  initial begin
    rst       = 1'b1;
    in_vld_i  = 1'b0;
    in_dat_i  = '0;
    errors    = 0;
    cycle_cnt = 0;
    lcg_state = 8054;
    for (int k = 0; k < PAIRS; k++) begin
      slot_a[k] = k;
      slot_b[k] = N - 1 - k;
    end
    repeat (10) @(posedge clk);
    rst <= 1'b0;
    test_reset_idle();
    test_first_round();
    test_full_sweep();
    test_gaps_busy();
    test_wrap();
    test_reload();
    $display("Errors: %0d check errors, %0d assertion failures",
             errors, u_dut.u_chk.fail_cnt);
    if (errors == 0 && u_dut.u_chk.fail_cnt == 0) begin
      $display("PASS: all tests");
    end else begin
      $display("FAIL: see errors above");
    end
    $finish;
  end

endmodule

//--- sim/jacobi_angle_front_chk.sv
`timescale 1ns/100ps

module jacobi_angle_front_chk
  import jacobi_pkg::*;
#(
  parameter int N = JACOBI_N
) (
  input logic                 clk,
  input logic                 rst,
  input logic [$clog2(N)-1:0] idx_i_i,
  input logic [$clog2(N)-1:0] idx_j_i,
  input logic                 vec_vld_i,
  input logic                 done_i
);

  int unsigned fail_cnt = 0;

  // Done marks the last pair, so it always rides on a strobe
  a_done_with_strobe: assert property (
    @(posedge clk) disable iff (rst) done_i |-> vec_vld_i
  ) else begin
    fail_cnt++;
    $error("sweep_done_o high without vec_vld_o");
  end

  a_pair_sorted: assert property (
    @(posedge clk) disable iff (rst) vec_vld_i |-> (idx_i_i < idx_j_i)
  ) else begin
    fail_cnt++;
    $error("pair presented with i not below j");
  end

  a_quiet_after_reset: assert property (
    @(posedge clk) rst |=> (!vec_vld_i && !done_i)
  ) else begin
    fail_cnt++;
    $error("strobe in the cycle after reset");
  end

endmodule

bind jacobi_angle_front jacobi_angle_front_chk #(
  .N (N)
) u_chk (
  .clk       (clk),
  .rst       (rst),
  .idx_i_i   (vec_i_o),
  .idx_j_i   (vec_j_o),
  .vec_vld_i (vec_vld_o),
  .done_i    (sweep_done_o)
);

//--- source/jacobi_angle_front.sv
`timescale 1ns/100ps

module jacobi_angle_front
  import jacobi_pkg::*;
#(
  parameter int N      = JACOBI_N,
  parameter int WORD_W = JACOBI_WORD_W,
  parameter int ROUNDS = JACOBI_ROUNDS
) (
  input  logic                     clk,
  input  logic                     rst,
  input  logic signed [WORD_W-1:0] in_dat_i,
  input  logic                     in_vld_i,
  output logic                     in_rdy_o,
  output logic signed [WORD_W-1:0] vec_x_o,
  output logic signed [WORD_W-1:0] vec_y_o,
  output logic [$clog2(N)-1:0]     vec_i_o,
  output logic [$clog2(N)-1:0]     vec_j_o,
  output logic                     vec_vld_o,
  output logic                     sweep_done_o
);

  localparam int IDX_W  = $clog2(N);
  localparam int ADDR_W = $clog2(N * N);

  logic                     wr_en;
  logic [ADDR_W-1:0]        wr_addr;
  logic signed [WORD_W-1:0] wr_dat;
  logic                     rd_en;
  logic [ADDR_W-1:0]        rd_addr_a;
  logic [ADDR_W-1:0]        rd_addr_b;
  read_phase_e              rd_phase;
  logic [IDX_W-1:0]         rd_i;
  logic [IDX_W-1:0]         rd_j;
  logic                     rd_last;

  // RAM side of the read tag
  logic signed [WORD_W-1:0] ram_dat_a;
  logic signed [WORD_W-1:0] ram_dat_b;
  logic                     ram_vld;
  read_phase_e              ram_phase;
  logic [IDX_W-1:0]         ram_i;
  logic [IDX_W-1:0]         ram_j;
  logic                     ram_last;

  jacobi_sweep_sequencer #(
    .N      (N),
    .WORD_W (WORD_W),
    .ROUNDS (ROUNDS)
  ) u_sequencer (
    .clk         (clk),
    .rst         (rst),
    .in_dat_i    (in_dat_i),
    .in_vld_i    (in_vld_i),
    .in_rdy_o    (in_rdy_o),
    .wr_en_o     (wr_en),
    .wr_addr_o   (wr_addr),
    .wr_dat_o    (wr_dat),
    .rd_en_o     (rd_en),
    .rd_addr_a_o (rd_addr_a),
    .rd_addr_b_o (rd_addr_b),
    .rd_phase_o  (rd_phase),
    .rd_i_o      (rd_i),
    .rd_j_o      (rd_j),
    .rd_last_o   (rd_last)
  );

  jacobi_matrix_ram #(
    .N      (N),
    .WORD_W (WORD_W)
  ) u_ram (
    .clk         (clk),
    .rst         (rst),
    .wr_en_i     (wr_en),
    .wr_addr_i   (wr_addr),
    .wr_dat_i    (wr_dat),
    .rd_en_i     (rd_en),
    .rd_addr_a_i (rd_addr_a),
    .rd_addr_b_i (rd_addr_b),
    .rd_phase_i  (rd_phase),
    .rd_i_i      (rd_i),
    .rd_j_i      (rd_j),
    .rd_last_i   (rd_last),
    .rd_dat_a_o  (ram_dat_a),
    .rd_dat_b_o  (ram_dat_b),
    .rd_vld_o    (ram_vld),
    .rd_phase_o  (ram_phase),
    .rd_i_o      (ram_i),
    .rd_j_o      (ram_j),
    .rd_last_o   (ram_last)
  );

  jacobi_angle_operands #(
    .N      (N),
    .WORD_W (WORD_W)
  ) u_operands (
    .clk          (clk),
    .rst          (rst),
    .rd_dat_a_i   (ram_dat_a),
    .rd_dat_b_i   (ram_dat_b),
    .rd_vld_i     (ram_vld),
    .rd_phase_i   (ram_phase),
    .rd_i_i       (ram_i),
    .rd_j_i       (ram_j),
    .rd_last_i    (ram_last),
    .vec_x_o      (vec_x_o),
    .vec_y_o      (vec_y_o),
    .vec_i_o      (vec_i_o),
    .vec_j_o      (vec_j_o),
    .vec_vld_o    (vec_vld_o),
    .sweep_done_o (sweep_done_o)
  );

endmodule

//--- source/jacobi_angle_operands.sv
`timescale 1ns/100ps

module jacobi_angle_operands
  import jacobi_pkg::*;
#(
  parameter int N      = JACOBI_N,
  parameter int WORD_W = JACOBI_WORD_W
) (
  input  logic                     clk,
  input  logic                     rst,

  // Tagged reads from the matrix RAM
  input  logic signed [WORD_W-1:0] rd_dat_a_i,
  input  logic signed [WORD_W-1:0] rd_dat_b_i,
  input  logic                     rd_vld_i,
  input  read_phase_e              rd_phase_i,
  input  logic [$clog2(N)-1:0]     rd_i_i,
  input  logic [$clog2(N)-1:0]     rd_j_i,
  input  logic                     rd_last_i,

  // Feed to the vectoring CORDIC
  output logic signed [WORD_W-1:0] vec_x_o,
  output logic signed [WORD_W-1:0] vec_y_o,
  output logic [$clog2(N)-1:0]     vec_i_o,
  output logic [$clog2(N)-1:0]     vec_j_o,
  output logic                     vec_vld_o,
  output logic                     sweep_done_o
);

  logic signed [WORD_W-1:0] wjj_q;
  logic signed [WORD_W-1:0] wij_q;
  logic                     diag_hit;
  logic                     offd_hit;

  assign diag_hit = rd_vld_i && (rd_phase_i == PH_DIAG);
  assign offd_hit = rd_vld_i && (rd_phase_i == PH_OFFD);

  // First read of a pair, kept until its second read arrives
  always_ff @(posedge clk) begin
    if (diag_hit) begin
      wjj_q <= rd_dat_a_i;
      wij_q <= rd_dat_b_i;
    end
  end

  // x = Wjj - Wii and y = 2*Wij, both wrap in WORD_W bits
  always_ff @(posedge clk) begin
    if (offd_hit) begin
      vec_x_o <= wjj_q - rd_dat_a_i;
      vec_y_o <= wij_q + rd_dat_b_i;
      vec_i_o <= rd_i_i;
      vec_j_o <= rd_j_i;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      vec_vld_o    <= 1'b0;
      sweep_done_o <= 1'b0;
    end else begin
      vec_vld_o    <= offd_hit;
      sweep_done_o <= offd_hit && rd_last_i;
    end
  end

endmodule

//--- source/jacobi_matrix_ram.sv
`timescale 1ns/100ps

module jacobi_matrix_ram
  import jacobi_pkg::*;
#(
  parameter int N      = JACOBI_N,
  parameter int WORD_W = JACOBI_WORD_W
) (
  input  logic                     clk,
  input  logic                     rst,
  input  logic                     wr_en_i,
  input  logic [$clog2(N*N)-1:0]   wr_addr_i,
  input  logic signed [WORD_W-1:0] wr_dat_i,
  input  logic                     rd_en_i,
  input  logic [$clog2(N*N)-1:0]   rd_addr_a_i,
  input  logic [$clog2(N*N)-1:0]   rd_addr_b_i,
  input  read_phase_e              rd_phase_i,
  input  logic [$clog2(N)-1:0]     rd_i_i,
  input  logic [$clog2(N)-1:0]     rd_j_i,
  input  logic                     rd_last_i,
  output logic signed [WORD_W-1:0] rd_dat_a_o,
  output logic signed [WORD_W-1:0] rd_dat_b_o,
  output logic                     rd_vld_o,
  output read_phase_e              rd_phase_o,
  output logic [$clog2(N)-1:0]     rd_i_o,
  output logic [$clog2(N)-1:0]     rd_j_o,
  output logic                     rd_last_o
);

  localparam int DEPTH  = N * N;
  localparam int ADDR_W = $clog2(DEPTH);

  logic signed [WORD_W-1:0] mem [DEPTH];
  logic [ADDR_W-1:0]        addr_a;

  // Port A serves the write, or a read when nothing is written
  assign addr_a = wr_en_i ? wr_addr_i : rd_addr_a_i;

  always_ff @(posedge clk) begin
    if (wr_en_i) begin
      mem[addr_a] <= wr_dat_i;
    end else if (rd_en_i) begin
      rd_dat_a_o <= mem[addr_a];
    end
    if (rd_en_i) begin
      rd_dat_b_o <= mem[rd_addr_b_i];
    end
  end

  // Tag follows the data through the read cycle
  always_ff @(posedge clk) begin
    if (rst) begin
      rd_vld_o <= 1'b0;
    end else begin
      rd_vld_o <= rd_en_i;
    end
    if (rd_en_i) begin
      rd_phase_o <= rd_phase_i;
      rd_i_o     <= rd_i_i;
      rd_j_o     <= rd_j_i;
      rd_last_o  <= rd_last_i;
    end
  end

endmodule

//--- source/jacobi_sweep_sequencer.sv
`timescale 1ns/100ps

module jacobi_sweep_sequencer
  import jacobi_pkg::*;
#(
  parameter int N      = JACOBI_N,
  parameter int WORD_W = JACOBI_WORD_W,
  parameter int ROUNDS = JACOBI_ROUNDS
) (
  input  logic                     clk,
  input  logic                     rst,

  // Matrix input, row-major
  input  logic signed [WORD_W-1:0] in_dat_i,
  input  logic                     in_vld_i,
  output logic                     in_rdy_o,

  // RAM write port
  output logic                     wr_en_o,
  output logic [$clog2(N*N)-1:0]   wr_addr_o,
  output logic signed [WORD_W-1:0] wr_dat_o,

  // RAM reads with their tag
  output logic                     rd_en_o,
  output logic [$clog2(N*N)-1:0]   rd_addr_a_o,
  output logic [$clog2(N*N)-1:0]   rd_addr_b_o,
  output read_phase_e              rd_phase_o,
  output logic [$clog2(N)-1:0]     rd_i_o,
  output logic [$clog2(N)-1:0]     rd_j_o,
  output logic                     rd_last_o
);

  localparam int IDX_W   = $clog2(N);
  localparam int ADDR_W  = $clog2(N * N);
  localparam int BEATS   = N * N;
  localparam int PAIRS   = N / 2;
  localparam int PAIR_W  = $clog2(PAIRS);
  localparam int ROUND_W = (ROUNDS > 1) ? $clog2(ROUNDS) : 1;

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_LOAD,
    ST_SWEEP
  } state_e;

  state_e             state_q;
  logic               accept;
  logic [ADDR_W-1:0]  beat_cnt_q;

  // Pair slots, first and second element of each
  logic [IDX_W-1:0]   slot_a_q [PAIRS];
  logic [IDX_W-1:0]   slot_b_q [PAIRS];

  logic [PAIR_W-1:0]  pair_cnt_q;
  read_phase_e        phase_q;
  logic [ROUND_W-1:0] round_cnt_q;
  logic               gap_q;

  logic               step;
  logic               pair_end;
  logic               round_end;
  logic               sweep_end;
  logic               permute;

  logic [IDX_W-1:0]   cur_a;
  logic [IDX_W-1:0]   cur_b;
  logic [IDX_W-1:0]   pair_i;
  logic [IDX_W-1:0]   pair_j;

  assign in_rdy_o = (state_q == ST_IDLE) || (state_q == ST_LOAD);
  assign accept   = in_vld_i && in_rdy_o;

  // One schedule step per sweep cycle, except the gap between rounds
  assign step      = (state_q == ST_SWEEP) && !gap_q;
  assign pair_end  = step && (phase_q == PH_OFFD);
  assign round_end = pair_end && (pair_cnt_q == PAIR_W'(PAIRS - 1));
  assign sweep_end = round_end && (round_cnt_q == ROUND_W'(ROUNDS - 1));
  assign permute   = gap_q || sweep_end;

  assign cur_a  = slot_a_q[pair_cnt_q];
  assign cur_b  = slot_b_q[pair_cnt_q];
  assign pair_i = (cur_a < cur_b) ? cur_a : cur_b;
  assign pair_j = (cur_a < cur_b) ? cur_b : cur_a;

  always_ff @(posedge clk) begin
    if (rst) begin
      state_q    <= ST_IDLE;
      beat_cnt_q <= '0;
    end else begin
      if (accept) begin
        beat_cnt_q <= beat_cnt_q + 1'b1;
      end
      case (state_q)
        ST_IDLE, ST_LOAD: begin
          if (accept) begin
            state_q <= (beat_cnt_q == ADDR_W'(BEATS - 1)) ? ST_SWEEP : ST_LOAD;
          end
        end
        ST_SWEEP: begin
          if (sweep_end) begin
            state_q <= ST_IDLE;
          end
        end
        default: state_q <= ST_IDLE;
      endcase
    end
  end

  // Pair, phase and round counters
  always_ff @(posedge clk) begin
    if (rst) begin
      pair_cnt_q  <= '0;
      phase_q     <= PH_DIAG;
      round_cnt_q <= '0;
      gap_q       <= 1'b0;
    end else if (step) begin
      phase_q <= (phase_q == PH_DIAG) ? PH_OFFD : PH_DIAG;
      if (pair_end) begin
        pair_cnt_q <= round_end ? '0 : pair_cnt_q + 1'b1;
      end
      if (round_end) begin
        round_cnt_q <= sweep_end ? '0 : round_cnt_q + 1'b1;
        gap_q       <= !sweep_end;
      end
    end else begin
      gap_q <= 1'b0;
    end
  end

  // Round-robin rotation around the fixed first element of slot 0
  always_ff @(posedge clk) begin
    if (rst) begin
      for (int k = 0; k < PAIRS; k++) begin
        slot_a_q[k] <= IDX_W'(k);
        slot_b_q[k] <= IDX_W'(N - 1 - k);
      end
    end else if (permute) begin
      slot_b_q[0] <= slot_a_q[1];
      for (int k = 1; k < PAIRS - 1; k++) begin
        slot_a_q[k] <= slot_a_q[k+1];
      end
      slot_a_q[PAIRS-1] <= slot_b_q[PAIRS-1];
      for (int k = 1; k < PAIRS; k++) begin
        slot_b_q[k] <= slot_b_q[k-1];
      end
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      wr_en_o <= 1'b0;
      rd_en_o <= 1'b0;
    end else begin
      wr_en_o <= accept;
      rd_en_o <= step;
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      wr_addr_o <= beat_cnt_q;
      wr_dat_o  <= in_dat_i;
    end
    if (step) begin
      // Port A fetches a diagonal word, port B always Wij
      if (phase_q == PH_DIAG) begin
        rd_addr_a_o <= ADDR_W'(matrix_addr(N, pair_j, pair_j));
      end else begin
        rd_addr_a_o <= ADDR_W'(matrix_addr(N, pair_i, pair_i));
      end
      rd_addr_b_o <= ADDR_W'(matrix_addr(N, pair_i, pair_j));
      rd_phase_o  <= phase_q;
      rd_i_o      <= pair_i;
      rd_j_o      <= pair_j;
      rd_last_o   <= sweep_end;
    end
  end

endmodule

//--- source/jacobi_pkg.sv
package jacobi_pkg;

  // Matrix dimension, even and a power of two
  parameter int JACOBI_N = 8;

  // Width of a matrix word
  parameter int JACOBI_WORD_W = 16;

  // A cyclic sweep visits every pair once in N-1 rounds
  parameter int JACOBI_ROUNDS = JACOBI_N - 1;

  // Read phase of a pair
  // PH_DIAG: port A reads Wjj, port B reads Wij
  // PH_OFFD: port A reads Wii, port B reads Wij
  typedef enum logic {
    PH_DIAG = 1'b0,
    PH_OFFD = 1'b1
  } read_phase_e;

  // Row-major address of element (row, col) in an n by n matrix
  function automatic int unsigned matrix_addr(
    input int unsigned n,
    input int unsigned row,
    input int unsigned col
  );
    int unsigned addr;
    addr = row * n + col;
    return addr;
  endfunction

endpackage
